// ==== files.f ====
sata_cmd_pkg.sv
settle_timer.sv
control_fsm.sv
dma_read_fsm.sv
dma_write_fsm.sv
h2d_register_file.sv
sata_command_layer.sv
tb_sata_command_layer.sv

// ==== tb_sata_command_layer.sv ====
// SATA command layer testbench
`timescale 1ns/1ps
`default_nettype none

module tb_sata_command_layer;

  import sata_cmd_pkg::*;

  localparam int RESET_TIMEOUT   = 8;
  localparam int RESET_CYCLES    = 10;
  localparam int NUM_TESTS       = 11;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + RESET_TIMEOUT + 200 * NUM_TESTS;
  localparam logic [31:0] SEED   = 32'ha56e_bd1b;

  typedef enum logic [1:0] {OP_USER, OP_READ, OP_WRITE} op_t;

  logic       clk;
  logic       rst;
  logic       send_user_command_stb;
  user_req_t  user_req;
  logic       read_data_en;
  logic       write_data_en;
  logic       single_rdwr;
  logic       soft_reset_en;
  logic       send_sync_escape;
  logic       transport_layer_ready;
  tl_events_t tl_events;
  d2h_regs_t  d2h_regs;
  logic       t_if_activate;
  logic       t_send_command_stb;
  logic       t_send_control_stb;
  logic       t_send_data_stb;
  logic       t_if_ready;
  logic       sync_escape;
  h2d_fis_t   h2d_fis;
  logic       command_layer_ready;
  logic       busy;
  logic       dev_error;
  logic       sata_init;

  // Expected-value tracking for the current operation
  op_t         op;
  lba_t        exp_lba;
  int          burst_left;
  int          strobes_this_enable;
  logic        pull_pending;
  logic        mute;
  logic [31:0] lcg_state;
  logic        quiet;

  sata_command_layer #(
    .RESET_TIMEOUT (RESET_TIMEOUT)
  ) i_dut (
    .clk                   (clk),
    .rst                   (rst),
    .send_user_command_stb (send_user_command_stb),
    .user_req              (user_req),
    .read_data_en          (read_data_en),
    .write_data_en         (write_data_en),
    .single_rdwr           (single_rdwr),
    .soft_reset_en         (soft_reset_en),
    .send_sync_escape      (send_sync_escape),
    .transport_layer_ready (transport_layer_ready),
    .tl_events             (tl_events),
    .d2h_regs              (d2h_regs),
    .t_if_activate         (t_if_activate),
    .t_send_command_stb    (t_send_command_stb),
    .t_send_control_stb    (t_send_control_stb),
    .t_send_data_stb       (t_send_data_stb),
    .t_if_ready            (t_if_ready),
    .sync_escape           (sync_escape),
    .h2d_fis               (h2d_fis),
    .command_layer_ready   (command_layer_ready),
    .busy                  (busy),
    .dev_error             (dev_error),
    .sata_init             (sata_init)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  assign quiet = busy && !t_send_command_stb && !t_send_control_stb && !t_send_data_stb &&
                 !t_if_ready && !sync_escape;

  task automatic report_error(input string msg);
    $display("FAIL at %0t ns: %s", $time, msg);
    $display(">>> FAIL");
    $fatal(1, "check failed");
  endtask

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Response delay of 1 to 4 cycles
  function automatic int rand_delay();
    logic [31:0] r;
    r = next_rand();
    return 1 + int'(r[17:16]);
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  // Reset and settle
  a_reset_quiet : assert property (@(posedge clk) rst ##1 rst |-> quiet)
  else report_error("busy low or strobe active during reset");

  a_init_time : assert property (@(posedge clk)
    $fell(rst) |-> (!sata_init && quiet) [*RESET_TIMEOUT] ##1 sata_init)
  else report_error("sata_init timing after reset is wrong");

  // Soft reset
  a_srst_set : assert property (@(posedge clk) disable iff (rst)
    $rose(soft_reset_en) && !h2d_fis.control[SRST_BIT]
    |=> t_send_control_stb && h2d_fis.control[SRST_BIT] && !sata_init)
  else report_error("no control pulse with SRST set after soft reset");

  a_srst_settle : assert property (@(posedge clk) disable iff (rst)
    t_send_control_stb && h2d_fis.control[SRST_BIT]
    |-> !sata_init [*RESET_TIMEOUT] ##1 sata_init)
  else report_error("settle time after soft reset is wrong");

  a_srst_release : assert property (@(posedge clk) disable iff (rst)
    h2d_fis.control[SRST_BIT] && !soft_reset_en && sata_init && transport_layer_ready
    |=> t_send_control_stb && !h2d_fis.control[SRST_BIT])
  else report_error("no control pulse with SRST clear at release");

  // DMA commands and continuation LBA
  a_read_cmd : assert property (@(posedge clk) disable iff (rst)
    t_send_command_stb && op == OP_READ
    |-> h2d_fis.command == CMD_DMA_READ_EXT && h2d_fis.lba == exp_lba &&
        h2d_fis.sector_count == user_req.sector_count)
  else report_error("read command FIS fields wrong");

  a_write_cmd : assert property (@(posedge clk) disable iff (rst)
    t_send_command_stb && op == OP_WRITE
    |-> h2d_fis.command == CMD_DMA_WRITE_EXT && h2d_fis.lba == exp_lba &&
        h2d_fis.sector_count == user_req.sector_count)
  else report_error("write command FIS fields wrong");

  // LBA mode device byte, no port multiplier
  a_fis_fixed : assert property (@(posedge clk) disable iff (rst)
    t_send_command_stb || t_send_control_stb
    |-> h2d_fis.device == 8'h40 && h2d_fis.port_mult == 4'h0)
  else report_error("device or port multiplier field wrong");

  a_single_shot : assert property (@(posedge clk) disable iff (rst)
    t_send_command_stb && single_rdwr && op != OP_USER |-> strobes_this_enable == 0)
  else report_error("more than one request in single mode");

  // Write data handshake
  a_grant : assert property (@(posedge clk) disable iff (rst)
    tl_events.dma_activate |-> ##2 t_if_ready)
  else report_error("t_if_ready missing after dma_activate");

  a_grant_close : assert property (@(posedge clk) disable iff (rst)
    t_if_ready && t_if_activate |=> !t_if_ready)
  else report_error("t_if_ready still high after pull");

  a_data_stb : assert property (@(posedge clk) disable iff (rst)
    t_send_data_stb |-> transport_layer_ready && pull_pending)
  else report_error("data strobe without ready or before a pull");

  // User command and busy
  a_user_cmd : assert property (@(posedge clk) disable iff (rst)
    $rose(send_user_command_stb)
    |=> t_send_command_stb && busy && h2d_fis.command == user_req.command &&
        h2d_fis.features == user_req.features ##1 !t_send_command_stb)
  else report_error("user command strobe or fields wrong");

  a_busy_rise : assert property (@(posedge clk) disable iff (rst)
    (t_send_command_stb || t_send_control_stb) && !send_sync_escape |=> busy)
  else report_error("busy did not rise after a send strobe");

  a_busy_fall : assert property (@(posedge clk) disable iff (rst)
    tl_events.d2h_reg && !t_send_command_stb && !t_send_control_stb &&
    !$rose(send_user_command_stb) |=> !busy)
  else report_error("busy did not fall after d2h register event");

  // Status capture
  a_dev_error : assert property (@(posedge clk) disable iff (rst)
    tl_events.d2h_reg || tl_events.set_device_bits
    |=> dev_error == $past(d2h_regs.status[STATUS_ERR_BIT]))
  else report_error("dev_error does not match captured status");

  a_dev_error_hold : assert property (@(posedge clk) disable iff (rst)
    !tl_events.d2h_reg && !tl_events.set_device_bits |=> $stable(dev_error))
  else report_error("dev_error changed without a status event");

  // Sync escape
  a_escape : assert property (@(posedge clk) disable iff (rst)
    send_sync_escape |=> sync_escape)
  else report_error("sync_escape pulse missing");

  a_escape_ready : assert property (@(posedge clk) disable iff (rst)
    send_sync_escape && !soft_reset_en && !h2d_fis.control[SRST_BIT]
    |=> (transport_layer_ready |-> command_layer_ready))
  else report_error("command_layer_ready low after sync escape");

  // Transport model: ends every command with a d2h register FIS
  task automatic finish_command();
    logic [31:0] hi;
    logic [31:0] lo;
    d2h_regs_t   regs;
    hi = next_rand();
    lo = next_rand();
    regs.status = hi[31:24];
    regs.lba    = {hi[15:0], lo};
    d2h_regs          <= regs;
    tl_events.d2h_reg <= 1'b1;
    if (!single_rdwr) begin
      exp_lba <= regs.lba + 1'b1;
    end
    // Last answer of a burst closes the enables
    if (burst_left == 1 && !single_rdwr) begin
      read_data_en  <= 1'b0;
      write_data_en <= 1'b0;
    end
    burst_left <= burst_left - 1;
    @(posedge clk);
    tl_events.d2h_reg <= 1'b0;
  endtask

  task automatic serve_read();
    wait_cycles(rand_delay());
    tl_events.d2h_data <= 1'b1;
    @(posedge clk);
    tl_events.d2h_data <= 1'b0;
    wait_cycles(rand_delay());
    finish_command();
  endtask

  task automatic serve_write();
    wait_cycles(rand_delay());
    tl_events.dma_activate <= 1'b1;
    @(posedge clk);
    tl_events.dma_activate <= 1'b0;
    while (!t_if_ready) @(posedge clk);
    // Pull the data and hold off the DUT for a while
    t_if_activate         <= 1'b1;
    transport_layer_ready <= 1'b0;
    pull_pending          <= 1'b1;
    @(posedge clk);
    t_if_activate <= 1'b0;
    wait_cycles(rand_delay());
    transport_layer_ready <= 1'b1;
    while (!t_send_data_stb) @(posedge clk);
    pull_pending <= 1'b0;
    wait_cycles(rand_delay());
    finish_command();
  endtask

  initial begin
    forever begin
      @(posedge clk);
      if (!rst && t_send_command_stb && !mute) begin
        strobes_this_enable <= strobes_this_enable + 1;
        case (op)
          OP_READ:  serve_read();
          OP_WRITE: serve_write();
          default: begin
            wait_cycles(rand_delay());
            finish_command();
          end
        endcase
      end
    end
  end

  task automatic run_user_command(input cmd_code_t cmd, input features_t feat);
    @(posedge clk);
    op                    <= OP_USER;
    single_rdwr           <= 1'b0;
    user_req.command      <= cmd;
    user_req.features     <= feat;
    burst_left            <= 1;
    send_user_command_stb <= 1'b1;
    @(posedge clk);
    while (burst_left != 0) @(posedge clk);
    send_user_command_stb <= 1'b0;
    wait_cycles(2);
  endtask

  task automatic run_soft_reset();
    @(posedge clk);
    soft_reset_en <= 1'b1;
    wait_cycles(3);
    soft_reset_en <= 1'b0;
    while (h2d_fis.control[SRST_BIT] || !sata_init) @(posedge clk);
    wait_cycles(2);
  endtask

  task automatic run_dma(input op_t kind, input int count, input logic single);
    logic [31:0] hi;
    logic [31:0] lo;
    hi = next_rand();
    lo = next_rand();
    @(posedge clk);
    op                      <= kind;
    single_rdwr             <= single;
    user_req.sector_address <= {hi[15:0], lo};
    user_req.sector_count   <= hi[31:16];
    exp_lba                 <= {hi[15:0], lo};
    burst_left              <= count;
    strobes_this_enable     <= 0;
    if (kind == OP_WRITE) begin
      write_data_en <= 1'b1;
    end else begin
      read_data_en <= 1'b1;
    end
    @(posedge clk);
    while (burst_left != 0) @(posedge clk);
    // Keep the enable up to show no second request
    if (single) begin
      wait_cycles(10);
      read_data_en  <= 1'b0;
      write_data_en <= 1'b0;
    end
    wait_cycles(2);
  endtask

  task automatic send_device_bits(input status_t value);
    @(posedge clk);
    d2h_regs.status           <= value;
    tl_events.set_device_bits <= 1'b1;
    @(posedge clk);
    tl_events.set_device_bits <= 1'b0;
    wait_cycles(2);
  endtask

  // Read left hanging by a silent transport, then escaped
  task automatic run_sync_escape();
    @(posedge clk);
    op           <= OP_READ;
    single_rdwr  <= 1'b0;
    mute         <= 1'b1;
    exp_lba      <= user_req.sector_address;
    read_data_en <= 1'b1;
    @(posedge clk);
    while (!t_send_command_stb) @(posedge clk);
    wait_cycles(3);
    send_sync_escape <= 1'b1;
    read_data_en     <= 1'b0;
    @(posedge clk);
    send_sync_escape <= 1'b0;
    while (!command_layer_ready) @(posedge clk);
    mute <= 1'b0;
    wait_cycles(2);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: test sequence did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display(">>> FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    rst                   = 1'b1;
    send_user_command_stb = 1'b0;
    user_req              = '0;
    read_data_en          = 1'b0;
    write_data_en         = 1'b0;
    single_rdwr           = 1'b0;
    soft_reset_en         = 1'b0;
    send_sync_escape      = 1'b0;
    transport_layer_ready = 1'b1;
    tl_events             = '0;
    d2h_regs              = '0;
    t_if_activate         = 1'b0;
    op                    = OP_USER;
    exp_lba               = '0;
    burst_left            = 0;
    strobes_this_enable   = 0;
    pull_pending          = 1'b0;
    mute                  = 1'b0;
    lcg_state             = SEED;

    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    while (!sata_init) @(posedge clk);

    run_user_command(8'hec, 16'h0003);
    run_soft_reset();
    run_dma(OP_READ, 4, 1'b0);
    run_dma(OP_READ, 1, 1'b1);
    run_dma(OP_READ, 1, 1'b1);
    run_dma(OP_WRITE, 3, 1'b0);
    run_dma(OP_WRITE, 1, 1'b1);
    send_device_bits(8'h41);
    send_device_bits(8'h50);
    run_sync_escape();
    run_dma(OP_READ, 2, 1'b0);

    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sata_command_layer.sv ====
// SATA command layer top
`timescale 1ns/1ps
`default_nettype none

module sata_command_layer #(
  parameter int RESET_TIMEOUT = 2
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    send_user_command_stb,
  input  sata_cmd_pkg::user_req_t  user_req,
  input  logic                    read_data_en,
  input  logic                    write_data_en,
  input  logic                    single_rdwr,
  input  logic                    soft_reset_en,
  input  logic                    send_sync_escape,
  input  logic                    transport_layer_ready,
  input  sata_cmd_pkg::tl_events_t tl_events,
  input  sata_cmd_pkg::d2h_regs_t  d2h_regs,
  input  logic                    t_if_activate,
  output logic                    t_send_command_stb,
  output logic                    t_send_control_stb,
  output logic                    t_send_data_stb,
  output logic                    t_if_ready,
  output logic                    sync_escape,
  output sata_cmd_pkg::h2d_fis_t   h2d_fis,
  output logic                    command_layer_ready,
  output logic                    busy,
  output logic                    dev_error,
  output logic                    sata_init
);

  logic timer_restart;
  logic srst;
  logic user_cmd_stb;
  logic read_start;
  logic read_idle;
  logic read_first;
  logic write_start;
  logic write_idle;
  logic write_first;

  settle_timer #(
    .RESET_TIMEOUT (RESET_TIMEOUT)
  ) i_settle_timer (
    .clk     (clk),
    .rst     (rst),
    .restart (timer_restart),
    .settled (sata_init)
  );

  control_fsm i_control_fsm (
    .clk                   (clk),
    .rst                   (rst),
    .soft_reset_en         (soft_reset_en),
    .send_user_command_stb (send_user_command_stb),
    .send_sync_escape      (send_sync_escape),
    .transport_layer_ready (transport_layer_ready),
    .settled               (sata_init),
    .read_idle             (read_idle),
    .write_idle            (write_idle),
    .read_start            (read_start),
    .write_start           (write_start),
    .tl_events             (tl_events),
    .d2h_status            (d2h_regs.status),
    .timer_restart         (timer_restart),
    .srst                  (srst),
    .t_send_control_stb    (t_send_control_stb),
    .t_send_command_stb    (t_send_command_stb),
    .user_cmd_stb          (user_cmd_stb),
    .layer_idle            (command_layer_ready),
    .busy                  (busy),
    .dev_error             (dev_error)
  );

  dma_read_fsm i_dma_read_fsm (
    .clk              (clk),
    .rst              (rst),
    .layer_idle       (command_layer_ready),
    .read_data_en     (read_data_en),
    .single_rdwr      (single_rdwr),
    .settled          (sata_init),
    .soft_reset_en    (soft_reset_en),
    .send_sync_escape (send_sync_escape),
    .tl_events        (tl_events),
    .read_start       (read_start),
    .read_idle        (read_idle),
    .read_first       (read_first),
    .sync_escape      (sync_escape)
  );

  dma_write_fsm i_dma_write_fsm (
    .clk                   (clk),
    .rst                   (rst),
    .layer_idle            (command_layer_ready),
    .write_data_en         (write_data_en),
    .single_rdwr           (single_rdwr),
    .settled               (sata_init),
    .soft_reset_en         (soft_reset_en),
    .send_sync_escape      (send_sync_escape),
    .t_if_activate         (t_if_activate),
    .transport_layer_ready (transport_layer_ready),
    .tl_events             (tl_events),
    .write_start           (write_start),
    .write_idle            (write_idle),
    .write_first           (write_first),
    .t_if_ready            (t_if_ready),
    .t_send_data_stb       (t_send_data_stb)
  );

  h2d_register_file i_h2d_register_file (
    .clk          (clk),
    .rst          (rst),
    .read_start   (read_start),
    .write_start  (write_start),
    .user_cmd_stb (user_cmd_stb),
    .read_first   (read_first),
    .write_first  (write_first),
    .single_rdwr  (single_rdwr),
    .srst         (srst),
    .d2h_reg_seen (tl_events.d2h_reg),
    .user_req     (user_req),
    .d2h_lba      (d2h_regs.lba),
    .h2d_fis      (h2d_fis)
  );

endmodule

`default_nettype wire

// ==== h2d_register_file.sv ====
// Host to device FIS registers
`timescale 1ns/1ps
`default_nettype none

module h2d_register_file (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   read_start,
  input  logic                   write_start,
  input  logic                   user_cmd_stb,
  input  logic                   read_first,
  input  logic                   write_first,
  input  logic                   single_rdwr,
  input  logic                   srst,
  input  logic                   d2h_reg_seen,
  input  sata_cmd_pkg::user_req_t user_req,
  input  sata_cmd_pkg::lba_t      d2h_lba,
  output sata_cmd_pkg::h2d_fis_t  h2d_fis
);

  import sata_cmd_pkg::*;

  cmd_code_t  command_q;
  features_t  features_q;
  lba_t       lba_q;
  lba_t       next_lba;
  logic       first_req;
  logic [7:0] control_byte;

  // Continuation requests pick up after the device's last LBA
  assign first_req = write_start ? write_first : read_first;
  assign next_lba  = (first_req || single_rdwr) ? user_req.sector_address : d2h_lba + 1'b1;

  always_ff @(posedge clk) begin
    if (rst) begin
      command_q  <= '0;
      features_q <= DEFAULT_FEATURES;
      lba_q      <= '0;
    end else begin
      if (write_start) begin
        command_q <= CMD_DMA_WRITE_EXT;
        lba_q     <= next_lba;
      end else if (read_start) begin
        command_q <= CMD_DMA_READ_EXT;
        lba_q     <= next_lba;
      end else if (user_cmd_stb) begin
        command_q <= user_req.command;
        lba_q     <= user_req.sector_address;
      end

      if (d2h_reg_seen) begin
        features_q <= DEFAULT_FEATURES;
      end
      if (user_cmd_stb) begin
        features_q <= user_req.features;
      end
    end
  end

  always_comb begin
    control_byte           = '0;
    control_byte[SRST_BIT] = srst;
  end

  always_comb begin
    h2d_fis.command      = command_q;
    h2d_fis.features     = features_q;
    h2d_fis.control      = control_byte;
    h2d_fis.port_mult    = 4'h0;
    h2d_fis.device       = DEFAULT_DEVICE;
    h2d_fis.lba          = lba_q;
    h2d_fis.sector_count = user_req.sector_count;
  end

endmodule

`default_nettype wire

// ==== dma_write_fsm.sv ====
// DMA write machine
`timescale 1ns/1ps
`default_nettype none

module dma_write_fsm (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    layer_idle,
  input  logic                    write_data_en,
  input  logic                    single_rdwr,
  input  logic                    settled,
  input  logic                    soft_reset_en,
  input  logic                    send_sync_escape,
  input  logic                    t_if_activate,
  input  logic                    transport_layer_ready,
  input  sata_cmd_pkg::tl_events_t tl_events,
  output logic                    write_start,
  output logic                    write_idle,
  output logic                    write_first,
  output logic                    t_if_ready,
  output logic                    t_send_data_stb
);

  import sata_cmd_pkg::*;

  write_state_t state;
  logic         single_done;
  logic         dma_act_seen;
  logic         abort;

  assign abort = soft_reset_en || send_sync_escape || !settled || tl_events.d2h_reg;

  assign write_idle  = (state == WR_IDLE);
  assign write_start = write_idle && layer_idle && write_data_en && !abort &&
                       !(single_rdwr && single_done);

  // Data FIS goes out as soon as the transport can take it
  assign t_send_data_stb = (state == WR_SEND_DATA) && transport_layer_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= WR_IDLE;
      single_done  <= 1'b0;
      write_first  <= 1'b1;
      dma_act_seen <= 1'b0;
      t_if_ready   <= 1'b0;
    end else begin
      if (!write_data_en) begin
        single_done <= 1'b0;
        write_first <= 1'b1;
      end else if (write_start && single_rdwr) begin
        single_done <= 1'b1;
      end

      // Grant closes once the transport starts pulling
      if (t_if_ready && t_if_activate) begin
        t_if_ready <= 1'b0;
      end

      case (state)
        WR_IDLE: begin
          if (write_start) begin
            state <= WR_WAIT_DMA_ACT;
          end
        end
        WR_WAIT_DMA_ACT: begin
          if (dma_act_seen) begin
            dma_act_seen <= 1'b0;
            write_first  <= 1'b0;
            t_if_ready   <= 1'b1;
            state        <= WR_WAIT_PULL;
          end
        end
        WR_WAIT_PULL: begin
          if (t_if_activate) begin
            state <= WR_SEND_DATA;
          end
        end
        WR_SEND_DATA: begin
          // Device may ask for more with another DMA activate
          if (transport_layer_ready) begin
            state <= WR_WAIT_DMA_ACT;
          end
        end
      endcase

      if (abort) begin
        state        <= WR_IDLE;
        t_if_ready   <= 1'b0;
        dma_act_seen <= 1'b0;
      end

      // Latched so a pulse during a busy state is not lost
      if (tl_events.dma_activate) begin
        dma_act_seen <= 1'b1;
      end
    end
  end

  // One data FIS per pull, sent after the grant has closed
  a_data_stb : assert property (@(posedge clk) disable iff (rst)
    t_send_data_stb |-> (state == WR_SEND_DATA) && transport_layer_ready && !t_if_ready
                        ##1 !t_send_data_stb)
  else $error("t_send_data_stb outside WR_SEND_DATA or without ready");

endmodule

`default_nettype wire

// ==== dma_read_fsm.sv ====
// DMA read request machine
`timescale 1ns/1ps
`default_nettype none

module dma_read_fsm (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    layer_idle,
  input  logic                    read_data_en,
  input  logic                    single_rdwr,
  input  logic                    settled,
  input  logic                    soft_reset_en,
  input  logic                    send_sync_escape,
  input  sata_cmd_pkg::tl_events_t tl_events,
  output logic                    read_start,
  output logic                    read_idle,
  output logic                    read_first,
  output logic                    sync_escape
);

  import sata_cmd_pkg::*;

  read_state_t state;
  logic        single_done;
  logic        cancel;
  logic        abort;

  // Cancel escapes a running read, d2h register FIS ends it normally
  assign cancel = soft_reset_en || send_sync_escape || !settled;
  assign abort  = cancel || tl_events.d2h_reg;

  assign read_idle  = (state == RD_IDLE);
  assign read_start = read_idle && layer_idle && read_data_en && !abort &&
                      !(single_rdwr && single_done);

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= RD_IDLE;
      single_done <= 1'b0;
      read_first  <= 1'b1;
      sync_escape <= 1'b0;
    end else begin
      sync_escape <= send_sync_escape || (cancel && !read_idle);

      // One request per enable in single mode
      if (!read_data_en) begin
        single_done <= 1'b0;
      end else if (read_start && single_rdwr) begin
        single_done <= 1'b1;
      end

      // Continuation addressing starts once data has arrived
      if (!read_data_en) begin
        read_first <= 1'b1;
      end else if (!read_idle && tl_events.d2h_data) begin
        read_first <= 1'b0;
      end

      case (state)
        RD_IDLE: begin
          if (read_start) begin
            state <= RD_WAIT_DATA;
          end
        end
        RD_WAIT_DATA: begin
          if (abort) begin
            state <= RD_IDLE;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== control_fsm.sv ====
// Command layer control and status
`timescale 1ns/1ps
`default_nettype none

module control_fsm (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    soft_reset_en,
  input  logic                    send_user_command_stb,
  input  logic                    send_sync_escape,
  input  logic                    transport_layer_ready,
  input  logic                    settled,
  input  logic                    read_idle,
  input  logic                    write_idle,
  input  logic                    read_start,
  input  logic                    write_start,
  input  sata_cmd_pkg::tl_events_t tl_events,
  input  sata_cmd_pkg::status_t    d2h_status,
  output logic                    timer_restart,
  output logic                    srst,
  output logic                    t_send_control_stb,
  output logic                    t_send_command_stb,
  output logic                    user_cmd_stb,
  output logic                    layer_idle,
  output logic                    busy,
  output logic                    dev_error
);

  import sata_cmd_pkg::*;

  ctrl_state_t state;
  status_t     status;
  logic        prev_user_cmd;
  logic        others_idle;
  logic        srst_start;
  logic        srst_release;

  assign others_idle = read_idle && write_idle && transport_layer_ready;
  assign layer_idle  = (state == CTRL_IDLE) && others_idle;

  // Soft reset breaks in from idle, release waits for the device to settle
  assign srst_start   = (state == CTRL_IDLE) && soft_reset_en;
  assign srst_release = (state == CTRL_SRST_HELD) && !soft_reset_en && settled && others_idle;

  assign timer_restart = srst_start;
  assign srst          = (state == CTRL_SRST_HELD);

  // Rising edge of the user command level
  assign user_cmd_stb = send_user_command_stb && !prev_user_cmd;

  assign dev_error = status[STATUS_ERR_BIT];

  always_ff @(posedge clk) begin
    if (rst) begin
      state              <= CTRL_IDLE;
      t_send_control_stb <= 1'b0;
      t_send_command_stb <= 1'b0;
      prev_user_cmd      <= 1'b0;
      status             <= '0;
      busy               <= 1'b1;
    end else begin
      t_send_control_stb <= srst_start || srst_release;
      t_send_command_stb <= read_start || write_start || user_cmd_stb;
      prev_user_cmd      <= send_user_command_stb;

      case (state)
        CTRL_IDLE: begin
          if (srst_start) begin
            state <= CTRL_SRST_HELD;
          end
        end
        CTRL_SRST_HELD: begin
          if (srst_release) begin
            state <= CTRL_IDLE;
          end
        end
      endcase

      // Device status register
      if (tl_events.d2h_reg || tl_events.set_device_bits) begin
        status <= d2h_status;
      end

      if (tl_events.d2h_reg) begin
        busy <= 1'b0;
      end
      if (t_send_command_stb || t_send_control_stb || user_cmd_stb) begin
        busy <= 1'b1;
      end
      // Escape always clears busy
      if (send_sync_escape) begin
        busy <= 1'b0;
      end
    end
  end

  // Control FIS pulses go out in set, clear, set order
  a_srst_alternate : assert property (@(posedge clk) disable iff (rst)
    t_send_control_stb == (srst != $past(srst)))
  else $error("control pulse does not toggle SRST");

endmodule

`default_nettype wire

// ==== settle_timer.sv ====
// Device settle timer
`timescale 1ns/1ps
`default_nettype none

module settle_timer #(
  parameter int RESET_TIMEOUT = 2
) (
  input  logic clk,
  input  logic rst,
  input  logic restart,
  output logic settled
);

  localparam int CNT_W = $clog2(RESET_TIMEOUT + 1);
  localparam logic [CNT_W-1:0] LIMIT = CNT_W'(RESET_TIMEOUT);

  logic [CNT_W-1:0] count;

  // Saturates at the limit
  always_ff @(posedge clk) begin
    if (rst || restart) begin
      count <= '0;
    end else if (count < LIMIT) begin
      count <= count + 1'b1;
    end
  end

  assign settled = (count >= LIMIT);

  // Device gets the full settle time after every soft reset
  a_settle_time : assert property (@(posedge clk) disable iff (rst)
    restart |=> !settled [*RESET_TIMEOUT])
  else $error("settled rose less than RESET_TIMEOUT cycles after restart");

endmodule

`default_nettype wire

// ==== sata_cmd_pkg.sv ====
// SATA command layer definitions
`default_nettype none

package sata_cmd_pkg;

  // Field widths
  localparam int LBA_W      = 48;
  localparam int SECT_CNT_W = 16;
  localparam int CMD_W      = 8;
  localparam int FEAT_W     = 16;
  localparam int STATUS_W   = 8;

  typedef logic [LBA_W-1:0]      lba_t;
  typedef logic [SECT_CNT_W-1:0] sector_count_t;
  typedef logic [CMD_W-1:0]      cmd_code_t;
  typedef logic [FEAT_W-1:0]     features_t;
  typedef logic [STATUS_W-1:0]   status_t;

  // ATA status register bits
  localparam int STATUS_ERR_BIT  = 0;
  localparam int STATUS_DRQ_BIT  = 3;
  localparam int STATUS_BUSY_BIT = 7;

  localparam cmd_code_t CMD_DMA_READ_EXT  = 8'h25;
  localparam cmd_code_t CMD_DMA_WRITE_EXT = 8'h35;

  localparam features_t  DEFAULT_FEATURES = '0;
  // LBA addressing mode
  localparam logic [7:0] DEFAULT_DEVICE   = 8'h40;
  // Soft reset bit in the device control byte
  localparam int         SRST_BIT         = 2;

  typedef struct packed {
    cmd_code_t     command;
    features_t     features;
    sector_count_t sector_count;
    lba_t          sector_address;
  } user_req_t;

  typedef struct packed {
    cmd_code_t     command;
    features_t     features;
    logic [7:0]    control;
    logic [3:0]    port_mult;
    logic [7:0]    device;
    lba_t          lba;
    sector_count_t sector_count;
  } h2d_fis_t;

  typedef struct packed {
    status_t status;
    lba_t    lba;
  } d2h_regs_t;

  // Single cycle strobes from the transport layer
  typedef struct packed {
    logic d2h_reg;
    logic set_device_bits;
    logic d2h_data;
    logic dma_activate;
  } tl_events_t;

  typedef enum logic [0:0] {CTRL_IDLE, CTRL_SRST_HELD} ctrl_state_t;
  typedef enum logic [0:0] {RD_IDLE, RD_WAIT_DATA} read_state_t;
  typedef enum logic [1:0] {
    WR_IDLE,
    WR_WAIT_DMA_ACT,
    WR_WAIT_PULL,
    WR_SEND_DATA
  } write_state_t;

endpackage

`default_nettype wire
